//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_mycpu
BUILD_DIR ?= obj_dir
FILELIST ?= list.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
+incdir+rtl
rtl/la_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/stage_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/exec_stage.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/mycpu_top.sv
sim/cpu_checker.sv
sim/tb_mycpu.sv

//--- rtl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Address of the first instruction fetched after reset
`define CPU_RESET_PC 32'h1c00_0000

// Integer data path width
`define CPU_XLEN 32

`define CPU_RF_AW 5    // Register number width, 32 general registers

`endif

//--- rtl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
    import pipe_pkg::*;
    import la_isa_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    stage_if.down        from_if,
    stage_if.up          to_ex,
    input  dest_info_t   ex_dest,
    input  dest_info_t   mem_dest,
    input  dest_info_t   wb_dest,
    input  rf_write_t    rf_wr,
    output br_redirect_t br
);

    logic        ds_valid;
    if_id_t      ds_bits;
    logic [31:0] inst;
    reg_t        rd;
    reg_t        rj;
    reg_t        rk;
    reg_t        rb;
    op_e         op;
    logic        rr_op;
    logic        use_rj;
    logic        use_b;
    logic        wr_op;
    logic [31:0] rf [32];
    logic [31:0] rj_val;
    logic [31:0] rb_val;
    logic [31:0] imm;
    logic [31:0] br_offs;
    logic        br_cond;
    logic        stall;
    logic        ds_go;

    function automatic logic dest_hit(input dest_info_t d, input reg_t r);
        return d.valid && d.dest == r && r != '0;
    endfunction

    // A register written in writeback this cycle is seen by decode straight away
    function automatic logic [31:0] rf_read(input reg_t r);
        logic [31:0] val;
        if (r == '0)
            val = '0;
        else if (dest_hit(wb_dest, r))
            val = rf_wr.data;
        else
            val = rf[r];
        return val;
    endfunction

    assign inst = ds_bits.inst;
    assign rd = inst[RD_LO +: $bits(reg_t)];
    assign rj = inst[RJ_LO +: $bits(reg_t)];
    assign rk = inst[RK_LO +: $bits(reg_t)];

    always_comb begin
        op = OP_NOP;
        if (inst[31:15] == OPC_ADD_W)       op = OP_ADD;
        else if (inst[31:15] == OPC_SUB_W)  op = OP_SUB;
        else if (inst[31:15] == OPC_AND)    op = OP_AND;
        else if (inst[31:15] == OPC_OR)     op = OP_OR;
        else if (inst[31:15] == OPC_XOR)    op = OP_XOR;
        else if (inst[31:15] == OPC_SLT)    op = OP_SLT;
        else if (inst[31:22] == OPC_ADDI_W) op = OP_ADDI;
        else if (inst[31:22] == OPC_LD_W)   op = OP_LD;
        else if (inst[31:22] == OPC_ST_W)   op = OP_ST;
        else if (inst[31:25] == OPC_LU12I_W) op = OP_LU12I;
        else if (inst[31:26] == OPC_BEQ)    op = OP_BEQ;
        else if (inst[31:26] == OPC_BNE)    op = OP_BNE;
        else if (inst[31:26] == OPC_B)      op = OP_B;
    end

    assign rr_op = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
    assign use_rj = !(op inside {OP_LU12I, OP_B, OP_NOP});
    assign use_b = rr_op || (op inside {OP_ST, OP_BEQ, OP_BNE});
    assign rb = rr_op ? rk : rd;    // Stores and compares take rd as second source
    assign wr_op = rr_op || (op inside {OP_ADDI, OP_LU12I, OP_LD});

    always_comb begin
        rj_val = rf_read(rj);
        rb_val = rf_read(rb);
    end

    assign imm = (op == OP_LU12I) ? {12'b0, inst[IMM20_LO +: 20]}
                                  : {{20{inst[IMM12_LO + 11]}}, inst[IMM12_LO +: 12]};

    // Wait for any producer still in execute or memory
    assign stall = (use_rj && (dest_hit(ex_dest, rj) || dest_hit(mem_dest, rj)))
                || (use_b && (dest_hit(ex_dest, rb) || dest_hit(mem_dest, rb)));

    assign ds_go = ds_valid && !stall && to_ex.allowin;
    assign from_if.allowin = !ds_valid || (!stall && to_ex.allowin);

    assign br_offs = (op == OP_B) ? {{4{inst[9]}}, inst[9:0], inst[OFFS_LO +: 16], 2'b0}
                                  : {{14{inst[25]}}, inst[OFFS_LO +: 16], 2'b0};
    assign br_cond = (op == OP_B) || (op == OP_BEQ && rj_val == rb_val)
                  || (op == OP_BNE && rj_val != rb_val);
    assign br.taken = ds_go && br_cond;
    assign br.target = ds_bits.pc + br_offs;

    assign to_ex.valid = ds_valid && !stall;
    assign to_ex.bits.pc = ds_bits.pc;
    assign to_ex.bits.op = op;
    assign to_ex.bits.src1 = rj_val;
    assign to_ex.bits.src2 = rr_op ? rb_val : imm;
    assign to_ex.bits.st_data = rb_val;
    assign to_ex.bits.dest = rd;
    assign to_ex.bits.wr = wr_op && rd != '0;

    always_ff @(posedge clk) begin
        if (!rst_n)
            ds_valid <= 1'b0;
        else if (from_if.allowin)
            ds_valid <= from_if.valid;
    end

    always_ff @(posedge clk) begin
        if (from_if.valid && from_if.allowin) begin
            ds_bits <= from_if.bits;
        end
    end

    always_ff @(posedge clk) begin
        if (rf_wr.we && rf_wr.addr != '0) begin
            rf[rf_wr.addr] <= rf_wr.data;
        end
    end

endmodule

//--- rtl/exec_stage.sv
`timescale 1ns/10ps

module exec_stage
    import pipe_pkg::*;
    import la_isa_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    stage_if.down       from_id,
    stage_if.up         to_mem,
    output dest_info_t  dest,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata
);

    logic        es_valid;
    id_ex_t      es_bits;
    logic [31:0] result;
    logic        es_go;
    logic        is_mem;

    assign from_id.allowin = !es_valid || to_mem.allowin;
    assign es_go = es_valid && to_mem.allowin;

    always_comb begin
        case (es_bits.op)
            OP_SUB:   result = es_bits.src1 - es_bits.src2;
            OP_AND:   result = es_bits.src1 & es_bits.src2;
            OP_OR:    result = es_bits.src1 | es_bits.src2;
            OP_XOR:   result = es_bits.src1 ^ es_bits.src2;
            OP_SLT:   result = {31'b0, $signed(es_bits.src1) < $signed(es_bits.src2)};
            OP_LU12I: result = {es_bits.src2[19:0], 12'b0};
            default:  result = es_bits.src1 + es_bits.src2;    // Also the load/store address
        endcase
    end

    // The access goes out in the same cycle the item moves to memory
    assign is_mem = es_bits.op inside {OP_LD, OP_ST};
    assign data_sram_en = es_go && is_mem;
    assign data_sram_we = (es_go && es_bits.op == OP_ST) ? 4'hf : 4'h0;
    assign data_sram_addr = result;
    assign data_sram_wdata = es_bits.st_data;

    assign to_mem.valid = es_valid;
    assign to_mem.bits.pc = es_bits.pc;
    assign to_mem.bits.op = es_bits.op;
    assign to_mem.bits.result = result;
    assign to_mem.bits.dest = es_bits.dest;
    assign to_mem.bits.wr = es_bits.wr;

    assign dest.valid = es_valid && es_bits.wr;
    assign dest.dest = es_bits.dest;

    always_ff @(posedge clk) begin
        if (!rst_n)
            es_valid <= 1'b0;
        else if (from_id.allowin)
            es_valid <= from_id.valid;
    end

    always_ff @(posedge clk) begin
        if (from_id.valid && from_id.allowin) begin
            es_bits <= from_id.bits;
        end
    end

endmodule

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module fetch_stage
    import pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    output logic         inst_sram_en,
    output logic [31:0]  inst_sram_addr,
    input  logic [31:0]  inst_sram_rdata,
    input  br_redirect_t br,
    stage_if.up          to_id
);

    logic        fetch_on;
    logic        fs_valid;
    logic        fs_allowin;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        buf_valid;
    logic [31:0] inst_buf;

    assign next_pc = br.taken ? br.target : pc + 32'd4;
    assign fs_allowin = !fs_valid || to_id.allowin;
    assign inst_sram_en = fetch_on && fs_allowin;    // Stays low until reset is released
    assign inst_sram_addr = next_pc;

    // A taken branch in decode drops the younger instruction held here
    assign to_id.valid = fs_valid && !br.taken;
    assign to_id.bits.pc = pc;
    assign to_id.bits.inst = buf_valid ? inst_buf : inst_sram_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_on <= 1'b0;
            fs_valid <= 1'b0;
            buf_valid <= 1'b0;
            pc <= `CPU_RESET_PC - 32'd4;
        end else begin
            fetch_on <= 1'b1;
            if (inst_sram_en) begin
                fs_valid <= 1'b1;
                buf_valid <= 1'b0;
                pc <= next_pc;
            end else if (fs_valid) begin
                buf_valid <= 1'b1;    // SRAM data is only there for one cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && !buf_valid) begin
            inst_buf <= inst_sram_rdata;
        end
    end

endmodule

//--- rtl/la_isa_pkg.sv
package la_isa_pkg;

    // Operations understood by the pipeline; anything else decodes to OP_NOP
    typedef enum logic [3:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
        OP_ADDI, OP_LU12I, OP_LD, OP_ST, OP_BEQ, OP_BNE, OP_B
    } op_e;

    localparam int RD_LO = 0;
    localparam int RJ_LO = 5;
    localparam int RK_LO = 10;
    localparam int IMM12_LO = 10;
    localparam int IMM20_LO = 5;
    localparam int OFFS_LO = 10;    // offs16, and the low half of offs26

    // 3R format, matched against inst[31:15]
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // 2RI12 format, matched against inst[31:22]
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_LD_W   = 10'h0a2;
    localparam logic [9:0] OPC_ST_W   = 10'h0a6;

    localparam logic [6:0] OPC_LU12I_W = 7'h0a;    // inst[31:25]

    // Branches, matched against inst[31:26]
    localparam logic [5:0] OPC_BEQ = 6'h16;
    localparam logic [5:0] OPC_BNE = 6'h17;
    localparam logic [5:0] OPC_B   = 6'h14;

endpackage

//--- rtl/mem_stage.sv
`timescale 1ns/10ps

module mem_stage
    import pipe_pkg::*;
    import la_isa_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    stage_if.down       from_ex,
    stage_if.up         to_wb,
    output dest_info_t  dest,
    input  logic [31:0] data_sram_rdata
);

    logic    ms_valid;
    ex_mem_t ms_bits;

    assign from_ex.allowin = !ms_valid || to_wb.allowin;

    assign to_wb.valid = ms_valid;
    assign to_wb.bits.pc = ms_bits.pc;
    // Load data arrives in this cycle and replaces the address
    assign to_wb.bits.result = (ms_bits.op == OP_LD) ? data_sram_rdata : ms_bits.result;
    assign to_wb.bits.dest = ms_bits.dest;
    assign to_wb.bits.wr = ms_bits.wr;

    assign dest.valid = ms_valid && ms_bits.wr;
    assign dest.dest = ms_bits.dest;

    always_ff @(posedge clk) begin
        if (!rst_n)
            ms_valid <= 1'b0;
        else if (from_ex.allowin)
            ms_valid <= from_ex.valid;
    end

    always_ff @(posedge clk) begin
        if (from_ex.valid && from_ex.allowin) begin
            ms_bits <= from_ex.bits;
        end
    end

endmodule

//--- rtl/mycpu_top.sv
`timescale 1ns/10ps

module mycpu_top
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // Instruction SRAM
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // Data SRAM
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // Retirement trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    stage_if #(.T(if_id_t))  if_id ();
    stage_if #(.T(id_ex_t))  id_ex ();
    stage_if #(.T(ex_mem_t)) ex_mem ();
    stage_if #(.T(mem_wb_t)) mem_wb ();

    dest_info_t   ex_dest;
    dest_info_t   mem_dest;
    dest_info_t   wb_dest;
    rf_write_t    rf_wr;
    br_redirect_t br;

    // Instruction memory is read only from the core
    assign inst_sram_we = 4'h0;
    assign inst_sram_wdata = 32'h0;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .br              (br),
        .to_id           (if_id.up)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .from_if  (if_id.down),
        .to_ex    (id_ex.up),
        .ex_dest  (ex_dest),
        .mem_dest (mem_dest),
        .wb_dest  (wb_dest),
        .rf_wr    (rf_wr),
        .br       (br)
    );

    exec_stage u_exec (
        .clk             (clk),
        .rst_n           (rst_n),
        .from_id         (id_ex.down),
        .to_mem          (ex_mem.up),
        .dest            (ex_dest),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage u_mem (
        .clk             (clk),
        .rst_n           (rst_n),
        .from_ex         (ex_mem.down),
        .to_wb           (mem_wb.up),
        .dest            (mem_dest),
        .data_sram_rdata (data_sram_rdata)
    );

    wb_stage u_wb (
        .clk               (clk),
        .rst_n             (rst_n),
        .from_mem          (mem_wb.down),
        .dest              (wb_dest),
        .rf_wr             (rf_wr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

//--- rtl/pipe_pkg.sv
`include "cpu_cfg.svh"

package pipe_pkg;
    import la_isa_pkg::*;

    typedef logic [`CPU_XLEN-1:0]  word_t;
    typedef logic [`CPU_RF_AW-1:0] reg_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        word_t pc;
        op_e   op;
        word_t src1;
        word_t src2;
        word_t st_data;
        reg_t  dest;
        logic  wr;       // Writes dest in writeback
    } id_ex_t;

    typedef struct packed {
        word_t pc;
        op_e   op;
        word_t result;   // ALU value or load/store address
        reg_t  dest;
        logic  wr;
    } ex_mem_t;

    typedef struct packed {
        word_t pc;
        word_t result;
        reg_t  dest;
        logic  wr;
    } mem_wb_t;

    // Pending register write of a later stage, seen by the decode interlock
    typedef struct packed {
        logic valid;
        reg_t dest;
    } dest_info_t;

    typedef struct packed {
        logic  we;
        reg_t  addr;
        word_t data;
    } rf_write_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_redirect_t;

endpackage

//--- rtl/stage_if.sv
`timescale 1ns/10ps

interface stage_if #(
    parameter type T = logic
) ();

    logic valid;      // Upstream stage offers an item
    logic allowin;    // Downstream stage takes it on this edge
    T     bits;

    // Producer side of the link
    modport up (
        output valid,
        output bits,
        input  allowin
    );

    // Consumer side of the link
    modport down (
        input  valid,
        input  bits,
        output allowin
    );

endinterface

//--- rtl/wb_stage.sv
`timescale 1ns/10ps

module wb_stage
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    stage_if.down       from_mem,
    output dest_info_t  dest,
    output rf_write_t   rf_wr,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic    ws_valid;
    mem_wb_t ws_bits;

    assign from_mem.allowin = 1'b1;    // Retires every cycle, never holds an item

    assign rf_wr.we = ws_valid && ws_bits.wr;
    assign rf_wr.addr = ws_bits.dest;
    assign rf_wr.data = ws_bits.result;

    assign dest.valid = ws_valid && ws_bits.wr;
    assign dest.dest = ws_bits.dest;

    assign debug_wb_pc = ws_bits.pc;
    assign debug_wb_rf_we = {4{rf_wr.we}};
    assign debug_wb_rf_wnum = ws_bits.dest;
    assign debug_wb_rf_wdata = ws_bits.result;

    always_ff @(posedge clk) begin
        if (!rst_n)
            ws_valid <= 1'b0;
        else
            ws_valid <= from_mem.valid;
    end

    always_ff @(posedge clk) begin
        if (from_mem.valid) begin
            ws_bits <= from_mem.bits;
        end
    end

endmodule

//--- sim/cpu_checker.sv
`timescale 1ns/10ps

module cpu_checker (
    input logic       clk,
    input logic       rst_n,
    input logic       inst_sram_en,
    input logic       data_sram_en,
    input logic [3:0] data_sram_we,
    input logic [3:0] debug_wb_rf_we,
    input logic [4:0] debug_wb_rf_wnum
);

    a_we_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        data_sram_we != 4'h0 |-> data_sram_en)
        else $error("data_sram_we set without data_sram_en");

    a_trace_we: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hf)
        else $error("debug_wb_rf_we is partly set");

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_rf_we != 4'h0 |-> debug_wb_rf_wnum != 5'd0)
        else $error("Write to r0 reported in the trace");

    // The first edge of reset only starts to clear the fetch state
    a_no_fetch_in_reset: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> !inst_sram_en)
        else $error("inst_sram_en high during reset");

endmodule

bind mycpu_top cpu_checker u_checker (.*);

//--- sim/tb_mycpu.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module tb_mycpu;

    localparam logic [31:0] BASE_PC = `CPU_RESET_PC;

    logic        clk;
    logic        rst_n;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [1024];
    logic [31:0] dmem [256];
    logic [31:0] ref_mem [256];
    logic [31:0] ref_rf [32];
    logic [31:0] ref_pc;
    logic [31:0] lfsr_state = 32'hfae1_3301;
    logic        i_en_q, d_en_q;
    logic [31:0] i_addr_q, d_addr_q, d_wdata_q;
    logic [3:0]  d_we_q;
    logic [31:0] sec_last_pc [8];
    string       sec_name [8];
    int          n_sec, cur_sec, prog_len, cycles, errors, sec_err, extra_writes;
    int          pass_count, fail_count;

    mycpu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_step()};
        return v;
    endfunction

    function automatic logic [31:0] sext(input logic [31:0] v, input int w);
        return (v << (32 - w)) >>> (32 - w) | ({32{v[w-1]}} << w);
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // The last write of a section marks its end in the trace
    task automatic end_section(input string name);
        emit({10'h00a, 12'(n_sec + 1), 5'd0, 5'd13});
        sec_last_pc[n_sec] = BASE_PC + 4 * (prog_len - 1);
        sec_name[n_sec] = name;
        n_sec++;
    endtask

    task automatic build_program();
        logic [16:0] rr_opc [6];
        logic [31:0] v;
        logic [31:0] r;
        rr_opc = '{17'h00020, 17'h00022, 17'h00029, 17'h0002a, 17'h0002b, 17'h00024};
        for (int i = 1; i < 8; i++)
            emit({10'h00a, 12'(rand_bits(12)), 5'd0, 5'(i)});
        for (int i = 0; i < 24; i++) begin
            r = rand_bits(3) % 7;
            if (r == 6)
                emit({10'h00a, 12'(rand_bits(12)), 5'(rand_bits(3)), 5'(rand_bits(3))});
            else
                emit({rr_opc[r], 5'(rand_bits(3)), 5'(rand_bits(3)), 5'(rand_bits(3))});
        end
        end_section("random ALU");
        emit({17'h00020, 5'd1, 5'd1, 5'd2});    // add r2, r1, r1
        emit({17'h00022, 5'd1, 5'd2, 5'd3});
        emit({17'h0002b, 5'd2, 5'd3, 5'd4});
        emit({10'h00a, 12'd5, 5'd4, 5'd4});
        emit({17'h0002a, 5'd3, 5'd4, 5'd5});
        emit({17'h00024, 5'd4, 5'd5, 5'd6});
        emit({17'h00029, 5'd5, 5'd6, 5'd7});
        emit({17'h00020, 5'd4, 5'd7, 5'd1});
        end_section("dependent chain");
        emit({10'h00a, 12'h040, 5'd0, 5'd8});
        emit({10'h0a6, 12'h000, 5'd8, 5'd1});    // st.w r1, r8, 0
        emit({10'h0a2, 12'h000, 5'd8, 5'd9});
        emit({17'h00020, 5'd9, 5'd9, 5'd10});    // Load result used at once
        emit({10'h0a6, 12'h008, 5'd8, 5'd10});
        emit({10'h0a2, 12'h048, 5'd0, 5'd11});
        emit({10'h0a2, 12'h020, 5'd8, 5'd12});
        end_section("store and load");
        emit({10'h00a, 12'd7, 5'd0, 5'd12});
        emit({6'h16, 16'd2, 5'd1, 5'd1});        // beq taken
        emit({10'h00a, 12'd1, 5'd0, 5'd2});
        emit({6'h17, 16'd2, 5'd1, 5'd1});        // bne not taken
        emit({10'h00a, 12'd2, 5'd0, 5'd3});
        emit({6'h17, 16'd2, 5'd12, 5'd0});       // bne taken
        emit({10'h00a, 12'd3, 5'd0, 5'd4});
        emit({6'h16, 16'd2, 5'd12, 5'd0});       // beq not taken
        emit({10'h00a, 12'd4, 5'd0, 5'd5});
        emit({6'h14, 16'd2, 10'd0});
        emit({10'h00a, 12'd5, 5'd0, 5'd6});
        end_section("branches");
        for (int i = 1; i < 4; i++) begin
            v = rand_bits(32);
            emit({7'h0a, v[31:12] + 20'(v[11]), 5'(i)});
            emit({10'h00a, v[11:0], 5'(i), 5'(i)});
        end
        emit({17'h00020, 5'd2, 5'd1, 5'd4});
        end_section("constants");
        emit({6'h14, 26'd0});                    // Self-loop
    endtask

    // Runs the shadow machine up to the next instruction that writes a register
    function automatic logic ref_step(output logic [31:0] pc, output logic [4:0] wnum,
                                      output logic [31:0] wdata);
        logic [31:0] inst, a, b, imm, res;
        logic [4:0]  rd;
        logic        wr;
        for (int n = 0; n < 4096; n++) begin
            inst = imem[ref_pc[11:2]];
            rd = inst[4:0];
            a = ref_rf[inst[9:5]];
            b = ref_rf[inst[14:10]];
            imm = sext({20'b0, inst[21:10]}, 12);
            pc = ref_pc;
            ref_pc = ref_pc + 4;
            wr = 1'b1;
            case (inst[31:15])
                17'h00020: res = a + b;
                17'h00022: res = a - b;
                17'h00029: res = a & b;
                17'h0002a: res = a | b;
                17'h0002b: res = a ^ b;
                17'h00024: res = {31'b0, $signed(a) < $signed(b)};
                default: begin
                    wr = 1'b0;
                    if (inst[31:22] == 10'h00a) begin
                        res = a + imm;
                        wr = 1'b1;
                    end else if (inst[31:22] == 10'h0a2) begin
                        res = ref_mem[8'((a + imm) >> 2)];
                        wr = 1'b1;
                    end else if (inst[31:22] == 10'h0a6) begin
                        ref_mem[8'((a + imm) >> 2)] = ref_rf[rd];
                    end else if (inst[31:25] == 7'h0a) begin
                        res = {inst[24:5], 12'b0};
                        wr = 1'b1;
                    end else if (inst[31:26] == 6'h14) begin
                        if (inst[25:0] == 26'd0) begin
                            ref_pc = pc;    // The program stays on its self-loop
                            return 1'b0;
                        end
                        ref_pc = pc + (sext({6'b0, inst[9:0], inst[25:10]}, 26) << 2);
                    end else if ((inst[31:26] == 6'h16 && a == ref_rf[rd])
                              || (inst[31:26] == 6'h17 && a != ref_rf[rd])) begin
                        ref_pc = pc + (sext({16'b0, inst[25:10]}, 16) << 2);
                    end
                end
            endcase
            if (wr && rd != 5'd0) begin
                ref_rf[rd] = res;
                wnum = rd;
                wdata = res;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %08h, expected %08h", name, got, exp);
            errors++;
            sec_err++;
        end
    endtask

    // SRAM requests are taken while stable and answered 2 ns after the edge
    always @(negedge clk) begin
        i_en_q = rst_n && inst_sram_en === 1'b1;
        i_addr_q = inst_sram_addr;
        d_en_q = rst_n && data_sram_en === 1'b1;
        d_we_q = data_sram_we;
        d_addr_q = data_sram_addr;
        d_wdata_q = data_sram_wdata;
    end

    always @(posedge clk) begin
        #2;
        if (i_en_q)
            inst_sram_rdata = imem[i_addr_q[11:2]];
        if (d_en_q && d_we_q != 4'h0) begin
            for (int b = 0; b < 4; b++)
                if (d_we_q[b])
                    dmem[d_addr_q[9:2]][8*b +: 8] = d_wdata_q[8*b +: 8];
        end else if (d_en_q) begin
            data_sram_rdata = dmem[d_addr_q[9:2]];
        end
    end

    always @(negedge clk) begin
        logic [31:0] epc, edata;
        logic [4:0]  ewnum;
        if (rst_n) begin
            check_value("inst_sram_we", 32'(inst_sram_we), 32'h0);
            check_value("inst_sram_wdata", inst_sram_wdata, 32'h0);
        end
        if (rst_n && debug_wb_rf_we != 4'h0 && debug_wb_rf_wnum != 5'd0) begin
            if (!ref_step(epc, ewnum, edata)) begin
                $display("Register write to r%0d after the end of the program",
                         debug_wb_rf_wnum);
                errors++;
                extra_writes++;
            end else begin
                check_value("debug_wb_pc", debug_wb_pc, epc);
                check_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(ewnum));
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, edata);
                if (cur_sec < n_sec && epc == sec_last_pc[cur_sec]) begin
                    $display("Test %0d %s: %s", cur_sec, sec_name[cur_sec],
                             sec_err == 0 ? "PASS" : "FAIL");
                    if (sec_err == 0)
                        pass_count++;
                    else
                        fail_count++;
                    sec_err = 0;
                    cur_sec++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 20 * prog_len + 200) begin
            $display("Timeout after %0d cycles, the pipeline stopped retiring", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        ref_pc = BASE_PC;
        for (int i = 0; i < 1024; i++)
            imem[i] = '0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hd0a0_0000 ^ (i * 32'h0001_0204);
            ref_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++)
            ref_rf[i] = '0;
        build_program();
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
        wait (cur_sec == n_sec);
        repeat (30) @(posedge clk);    // Any write seen here is one too many
        $display("Test %0d trace end: %s", n_sec, extra_writes == 0 ? "PASS" : "FAIL");
        if (extra_writes == 0)
            pass_count++;
        else
            fail_count++;
        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
